// File: common/u2_settings.svh
// Settings bus register map, reset values, compatibility number and time base
`ifndef U2_SETTINGS_SVH
`define U2_SETTINGS_SVH

////////////////////////////////////////
// Miscellaneous register block
////////////////////////////////////////
`define SR_MISC           0

`define SR_CLK_OFS        0   // Clock gen control
`define SR_SER_OFS        1   // SERDES control
`define SR_ADC_OFS        2   // ADC enables
`define SR_LED_OFS        3   // Software LED values
`define SR_PHY_OFS        4   // PHY reset, active high in the register
`define SR_BLDR_OFS       5   // Bootloader done flag
`define SR_LEDSRC_OFS     6   // LED source select, 1 = hardware

// LED bits 1 to 4 start under hardware control
`define LED_SRC_AT_RESET  8'h1E

////////////////////////////////////////
// VITA time registers
////////////////////////////////////////
`define SR_TIME64         10

`define SR_TIME_SECS_OFS  0   // Pending seconds
`define SR_TIME_TICKS_OFS 1   // Ticks, loads the full time

`define TICKS_PER_SEC     104000000

// Bump when the register map changes in a way software can see
`define COMPAT_MAJOR      8
`define COMPAT_MINOR      2

////////////////////////////////////////
// Readback word indices
////////////////////////////////////////
`define RB_TIME_SECS      10
`define RB_TIME_TICKS     11
`define RB_COMPAT         12
`define RB_FLAGS          13
`define RB_PPS_SECS       14
`define RB_PPS_TICKS      15

`endif

// File: common/ctrl_pkg.sv
// Settings bus, board control line, readback and boot sequencer types
package ctrl_pkg;

   typedef logic [7:0]  set_addr_t;
   typedef logic [31:0] set_data_t;

   // One settings write per cycle with stb high
   typedef struct packed {
      logic      stb;
      set_addr_t addr;
      set_data_t data;
   } set_bus_t;

   typedef logic [7:0] ctrl_byte_t;

   // Everything the setting bank drives onto the board
   typedef struct packed {
      logic       clock_ready;
      logic [1:0] clk_en;
      logic [1:0] clk_sel;
      logic       ser_enable;
      logic       ser_prbsen;
      logic       ser_loopen;
      logic       ser_rx_en;
      logic       adc_oe_a;
      logic       adc_on_a;
      logic       adc_oe_b;
      logic       adc_on_b;
   } board_ctrl_t;

   typedef enum logic {
      BLDR_WAIT,  // Bootloader running from boot RAM
      BLDR_DONE   // Main image released, stays here until power-on reset
   } boot_state_e;

   typedef logic [15:0] wb_addr_t;   // CPU byte address
   typedef logic [31:0] rb_word_t;
   typedef logic [3:0]  rb_index_t;

endpackage

// File: common/time_pkg.sv
// VITA time types, seconds and ticks
package time_pkg;

   typedef logic [31:0] secs_t;
   typedef logic [31:0] ticks_t;   // Counts dsp_clk cycles within one second

   // Seconds in the upper word, as read back by software
   typedef struct packed {
      secs_t  secs;
      ticks_t ticks;
   } vita_time_t;

endpackage

// File: src/boot_reset_seq.sv
// Bootloader reset FSM, core reset generation and boot RAM window swap
module boot_reset_seq (
   input  logic               dsp_clk,
   input  logic               por_rst,
   input  logic               bldr_done_i,
   input  ctrl_pkg::wb_addr_t cpu_adr_i,
   output logic               core_rst_o,
   output ctrl_pkg::wb_addr_t mem_adr_o
);
   import ctrl_pkg::*;

   boot_state_e state_q;
   logic        rel_pulse_q;   // Extra reset once the boot code is finished

   ////////////////////////////////////////
   // Boot state machine
   ////////////////////////////////////////
   always_ff @(posedge dsp_clk) begin
      if (por_rst) begin
         state_q     <= BLDR_WAIT;
         rel_pulse_q <= 1'b0;
      end else begin
         rel_pulse_q <= 1'b0;
         case (state_q)
            BLDR_WAIT: begin
               if (bldr_done_i) begin   // Flag written by the bootloader
                  state_q     <= BLDR_DONE;
                  rel_pulse_q <= 1'b1;
               end
            end
            BLDR_DONE: begin
               state_q <= BLDR_DONE;   // No way back short of power-on reset
            end
            default: begin
               state_q <= BLDR_WAIT;
            end
         endcase
      end
   end

   // Power-on reset passes straight through, pulse adds one cycle
   assign core_rst_o = por_rst | rel_pulse_q;

   ////////////////////////////////////////
   // Address window swap
   ////////////////////////////////////////
   // Boot RAM sits at the top 16K, main RAM at the bottom 16K
   always_comb begin
      mem_adr_o = cpu_adr_i;
      if ((state_q == BLDR_WAIT) && (cpu_adr_i[15] == cpu_adr_i[14])) begin
         mem_adr_o = cpu_adr_i ^ 16'hC000;
      end
   end

endmodule

// File: vita/vita_time_counter.sv
// VITA 64-bit time counter with settings load, second rollover and PPS capture
`include "u2_settings.svh"

module vita_time_counter (
   input  logic                 dsp_clk,
   input  logic                 core_rst_i,
   input  ctrl_pkg::set_bus_t   set_bus_i,
   input  logic                 pps_i,
   output time_pkg::vita_time_t vita_time_o,
   output time_pkg::vita_time_t pps_time_o,
   output logic                 pps_int_o
);
   import ctrl_pkg::*;
   import time_pkg::*;

   localparam set_addr_t ADDR_SECS  = set_addr_t'(`SR_TIME64 + `SR_TIME_SECS_OFS);
   localparam set_addr_t ADDR_TICKS = set_addr_t'(`SR_TIME64 + `SR_TIME_TICKS_OFS);
   localparam ticks_t    TICK_LAST  = ticks_t'(`TICKS_PER_SEC - 1);

   secs_t      secs_pend_q;   // Held until the ticks write
   vita_time_t time_q;
   vita_time_t pps_time_q;
   logic       pps_q;
   logic       pps_int_q;
   logic       load_secs;
   logic       load_time;
   logic       pps_rise;

   assign load_secs = set_bus_i.stb && (set_bus_i.addr == ADDR_SECS);
   assign load_time = set_bus_i.stb && (set_bus_i.addr == ADDR_TICKS);

   ////////////////////////////////////////
   // Time load and free-running count
   ////////////////////////////////////////
   always_ff @(posedge dsp_clk) begin
      if (core_rst_i) begin
         secs_pend_q <= '0;
      end else if (load_secs) begin
         secs_pend_q <= set_bus_i.data;
      end
   end

   always_ff @(posedge dsp_clk) begin
      if (core_rst_i) begin
         time_q <= '0;
      end else if (load_time) begin
         time_q.secs  <= secs_pend_q;
         time_q.ticks <= set_bus_i.data;   // Ticks write commits both halves
      end else if (time_q.ticks == TICK_LAST) begin
         time_q.ticks <= '0;
         time_q.secs  <= time_q.secs + secs_t'(1);
      end else begin
         time_q.ticks <= time_q.ticks + ticks_t'(1);
      end
   end

   ////////////////////////////////////////
   // PPS edge and capture
   ////////////////////////////////////////
   assign pps_rise = pps_i & ~pps_q;

   always_ff @(posedge dsp_clk) begin
      if (core_rst_i) begin
         pps_q      <= 1'b0;
         pps_int_q  <= 1'b0;
         pps_time_q <= '0;
      end else begin
         pps_q     <= pps_i;
         pps_int_q <= pps_rise;   // Single cycle per rising edge
         if (pps_rise) begin
            pps_time_q <= time_q;
         end
      end
   end

   assign vita_time_o = time_q;
   assign pps_time_o  = pps_time_q;
   assign pps_int_o   = pps_int_q;

endmodule

// File: src/misc_setting_bank.sv
// Miscellaneous setting registers, board control lines, PHY reset and LED source mux
`include "u2_settings.svh"

module misc_setting_bank (
   input  logic                  dsp_clk,
   input  logic                  core_rst_i,
   input  ctrl_pkg::set_bus_t    set_bus_i,
   input  logic                  run_rx_i,
   input  logic                  run_tx_i,
   input  logic                  clk_status_i,
   input  logic                  serdes_link_up_i,
   output ctrl_pkg::board_ctrl_t board_ctrl_o,
   output logic                  phy_resetn_o,
   output logic                  bldr_done_o,
   output ctrl_pkg::ctrl_byte_t  leds_o
);
   import ctrl_pkg::*;

   localparam set_addr_t ADDR_CLK    = set_addr_t'(`SR_MISC + `SR_CLK_OFS);
   localparam set_addr_t ADDR_SER    = set_addr_t'(`SR_MISC + `SR_SER_OFS);
   localparam set_addr_t ADDR_ADC    = set_addr_t'(`SR_MISC + `SR_ADC_OFS);
   localparam set_addr_t ADDR_LED    = set_addr_t'(`SR_MISC + `SR_LED_OFS);
   localparam set_addr_t ADDR_PHY    = set_addr_t'(`SR_MISC + `SR_PHY_OFS);
   localparam set_addr_t ADDR_BLDR   = set_addr_t'(`SR_MISC + `SR_BLDR_OFS);
   localparam set_addr_t ADDR_LEDSRC = set_addr_t'(`SR_MISC + `SR_LEDSRC_OFS);

   board_ctrl_t board_ctrl_q;
   logic        phy_rst_q;     // High holds the PHY in reset
   logic        bldr_done_q;
   ctrl_byte_t  led_sw_q;
   ctrl_byte_t  led_src_q;
   ctrl_byte_t  led_hw;
   ctrl_byte_t  leds_q;

   ////////////////////////////////////////
   // Register decode
   ////////////////////////////////////////
   always_ff @(posedge dsp_clk) begin
      if (core_rst_i) begin
         board_ctrl_q <= '0;
         phy_rst_q    <= 1'b0;
         bldr_done_q  <= 1'b0;
         led_sw_q     <= '0;
         led_src_q    <= `LED_SRC_AT_RESET;
      end else if (set_bus_i.stb) begin
         case (set_bus_i.addr)
            ADDR_CLK: begin
               {board_ctrl_q.clock_ready, board_ctrl_q.clk_en,
                board_ctrl_q.clk_sel} <= set_bus_i.data[4:0];
            end
            ADDR_SER: begin
               {board_ctrl_q.ser_enable, board_ctrl_q.ser_prbsen,
                board_ctrl_q.ser_loopen, board_ctrl_q.ser_rx_en} <= set_bus_i.data[3:0];
            end
            ADDR_ADC: begin
               {board_ctrl_q.adc_oe_a, board_ctrl_q.adc_on_a,
                board_ctrl_q.adc_oe_b, board_ctrl_q.adc_on_b} <= set_bus_i.data[3:0];
            end
            ADDR_LED:    led_sw_q    <= set_bus_i.data[7:0];
            ADDR_PHY:    phy_rst_q   <= set_bus_i.data[0];
            ADDR_BLDR:   bldr_done_q <= set_bus_i.data[0];
            ADDR_LEDSRC: led_src_q   <= set_bus_i.data[7:0];
            default: begin
               // Address belongs to another block
            end
         endcase
      end
   end

   assign board_ctrl_o = board_ctrl_q;
   assign phy_resetn_o = ~phy_rst_q;
   assign bldr_done_o  = bldr_done_q;

   ////////////////////////////////////////
   // LED source mux
   ////////////////////////////////////////
   assign led_hw = {3'b000, run_tx_i, run_rx_i, clk_status_i, serdes_link_up_i, 1'b0};

   // Source bit set picks the hardware bit
   always_ff @(posedge dsp_clk) begin
      if (core_rst_i) begin
         leds_q <= '0;
      end else begin
         leds_q <= (led_src_q & led_hw) | (~led_src_q & led_sw_q);
      end
   end

   assign leds_o = leds_q;

endmodule

// File: src/status_readback.sv
// Registered sixteen-word status readback mux with compatibility and flag words
`include "u2_settings.svh"

module status_readback (
   input  logic                 dsp_clk,
   input  logic                 core_rst_i,
   input  ctrl_pkg::rb_index_t  rb_index_i,
   input  time_pkg::vita_time_t vita_time_i,
   input  time_pkg::vita_time_t pps_time_i,
   input  logic                 clk_status_i,
   input  logic                 serdes_link_up_i,
   input  logic                 button_i,
   output ctrl_pkg::rb_word_t   rb_data_o
);
   import ctrl_pkg::*;

   rb_word_t compat_word;
   rb_word_t flags_word;
   rb_word_t rb_q;

   assign compat_word = {16'(`COMPAT_MAJOR), 16'(`COMPAT_MINOR)};   // Major high, minor low

   // Bit 13 button, bit 11 clock status, bit 10 SERDES link
   assign flags_word = {18'b0, button_i, 1'b0, clk_status_i, serdes_link_up_i, 10'b0};

   always_ff @(posedge dsp_clk) begin
      if (core_rst_i) begin
         rb_q <= '0;
      end else begin
         case (rb_index_i)
            rb_index_t'(`RB_TIME_SECS):  rb_q <= vita_time_i.secs;
            rb_index_t'(`RB_TIME_TICKS): rb_q <= vita_time_i.ticks;
            rb_index_t'(`RB_COMPAT):     rb_q <= compat_word;
            rb_index_t'(`RB_FLAGS):      rb_q <= flags_word;
            rb_index_t'(`RB_PPS_SECS):   rb_q <= pps_time_i.secs;
            rb_index_t'(`RB_PPS_TICKS):  rb_q <= pps_time_i.ticks;
            default:                     rb_q <= '0;   // Overflow, pool, GPIO words
         endcase
      end
   end

   assign rb_data_o = rb_q;

endmodule

// File: src/u2_ctrl_core.sv
// Control plane top with boot reset sequencer, setting bank, time counter and readback
module u2_ctrl_core (
   input  logic                  dsp_clk,
   input  logic                  por_rst,
   input  ctrl_pkg::set_bus_t    set_bus_i,
   input  logic                  pps_i,
   input  ctrl_pkg::wb_addr_t    cpu_adr_i,
   input  logic                  run_rx_i,
   input  logic                  run_tx_i,
   input  logic                  clk_status_i,
   input  logic                  serdes_link_up_i,
   input  logic                  button_i,
   input  ctrl_pkg::rb_index_t   rb_index_i,
   output ctrl_pkg::board_ctrl_t board_ctrl_o,
   output logic                  phy_resetn_o,
   output ctrl_pkg::ctrl_byte_t  leds_o,
   output logic                  core_rst_o,
   output ctrl_pkg::wb_addr_t    mem_adr_o,
   output logic                  pps_int_o,
   output ctrl_pkg::rb_word_t    rb_data_o
);
   import time_pkg::*;

   logic       core_rst;    // Power-on reset or boot release pulse
   logic       bldr_done;
   vita_time_t vita_time;
   vita_time_t pps_time;

   ////////////////////////////////////////
   // Reset and boot control
   ////////////////////////////////////////
   boot_reset_seq u_boot_reset_seq (
      .dsp_clk     (dsp_clk),
      .por_rst     (por_rst),
      .bldr_done_i (bldr_done),
      .cpu_adr_i   (cpu_adr_i),
      .core_rst_o  (core_rst),
      .mem_adr_o   (mem_adr_o)
   );

   assign core_rst_o = core_rst;

   misc_setting_bank u_misc_setting_bank (
      .dsp_clk          (dsp_clk),
      .core_rst_i       (core_rst),
      .set_bus_i        (set_bus_i),
      .run_rx_i         (run_rx_i),
      .run_tx_i         (run_tx_i),
      .clk_status_i     (clk_status_i),
      .serdes_link_up_i (serdes_link_up_i),
      .board_ctrl_o     (board_ctrl_o),
      .phy_resetn_o     (phy_resetn_o),
      .bldr_done_o      (bldr_done),
      .leds_o           (leds_o)
   );

   ////////////////////////////////////////
   // Time and status
   ////////////////////////////////////////
   vita_time_counter u_vita_time_counter (
      .dsp_clk     (dsp_clk),
      .core_rst_i  (core_rst),
      .set_bus_i   (set_bus_i),
      .pps_i       (pps_i),
      .vita_time_o (vita_time),
      .pps_time_o  (pps_time),
      .pps_int_o   (pps_int_o)
   );

   status_readback u_status_readback (
      .dsp_clk          (dsp_clk),
      .core_rst_i       (core_rst),
      .rb_index_i       (rb_index_i),
      .vita_time_i      (vita_time),
      .pps_time_i       (pps_time),
      .clk_status_i     (clk_status_i),
      .serdes_link_up_i (serdes_link_up_i),
      .button_i         (button_i),
      .rb_data_o        (rb_data_o)
   );

endmodule

// File: tb/u2_ctrl_core_props.sv
// Concurrent checks on core reset and PPS interrupt pulses, bound into the top level
module u2_ctrl_core_props (
   input logic dsp_clk,
   input logic por_rst,
   input logic core_rst_i,
   input logic pps_int_i
);
   logic core_rst_q;
   logic rst_rose_q;   // Core reset already pulsed since power-on reset

   always_ff @(posedge dsp_clk) begin
      if (por_rst) begin
         core_rst_q <= 1'b1;
         rst_rose_q <= 1'b0;
      end else begin
         core_rst_q <= core_rst_i;
         if (core_rst_i && !core_rst_q) begin
            rst_rose_q <= 1'b1;
         end
      end
   end

   pps_single: assert property (@(posedge dsp_clk) disable iff (por_rst)
      pps_int_i |=> !pps_int_i)
      else $error("pps_int_o high for two cycles in a row");

   por_release: assert property (@(posedge dsp_clk) $fell(por_rst) |-> !core_rst_i)
      else $error("core_rst_o still high after por_rst fell");

   one_release: assert property (@(posedge dsp_clk) disable iff (por_rst)
      (core_rst_i && !core_rst_q) |-> !rst_rose_q)
      else $error("core_rst_o rose twice without a power-on reset");

endmodule

bind u2_ctrl_core u2_ctrl_core_props u_u2_ctrl_core_props (
   .dsp_clk    (dsp_clk),
   .por_rst    (por_rst),
   .core_rst_i (core_rst_o),
   .pps_int_i  (pps_int_o)
);

// File: tb/tb_u2_ctrl_core.sv
// Testbench for the control plane core with pattern player, output checks and summary
module tb_u2_ctrl_core;
   import ctrl_pkg::*;

   localparam int PPS_TIMEOUT = 20;   // Cycles to wait for the interrupt
   localparam int PPS_WINDOW  = 8;    // Cycles watched for extra pulses

   logic        dsp_clk;
   logic        por_rst;
   set_bus_t    set_bus;
   logic        pps;
   wb_addr_t    cpu_adr;
   logic        run_rx;
   logic        run_tx;
   logic        clk_status;
   logic        serdes_link_up;
   logic        button;
   rb_index_t   rb_index;
   board_ctrl_t board_ctrl;
   logic        phy_resetn;
   ctrl_byte_t  leds;
   logic        core_rst;
   wb_addr_t    mem_adr;
   logic        pps_int;
   rb_word_t    rb_data;

   logic [31:0] lfsr;
   int          errors;
   int          tests;
   int          failed;

   u2_ctrl_core u_u2_ctrl_core (
      .dsp_clk          (dsp_clk),
      .por_rst          (por_rst),
      .set_bus_i        (set_bus),
      .pps_i            (pps),
      .cpu_adr_i        (cpu_adr),
      .run_rx_i         (run_rx),
      .run_tx_i         (run_tx),
      .clk_status_i     (clk_status),
      .serdes_link_up_i (serdes_link_up),
      .button_i         (button),
      .rb_index_i       (rb_index),
      .board_ctrl_o     (board_ctrl),
      .phy_resetn_o     (phy_resetn),
      .leds_o           (leds),
      .core_rst_o       (core_rst),
      .mem_adr_o        (mem_adr),
      .pps_int_o        (pps_int),
      .rb_data_o        (rb_data)
   );

   initial begin
      dsp_clk = 1'b0;
      forever #50 dsp_clk = ~dsp_clk;
   end

   ////////////////////////////////////////
   // Helpers
   ////////////////////////////////////////
   // Galois form, taps 32 22 2 1
   function automatic logic [31:0] lfsr_next(input logic [31:0] state);
      if (state[0]) begin
         return (state >> 1) ^ 32'h8020_0003;
      end
      return state >> 1;
   endfunction

   task automatic idle_gap();
      int n;
      n = 0;
      for (int i = 0; i < 2; i++) begin
         lfsr = lfsr_next(lfsr);
         n = n * 2 + int'(lfsr[0]);
      end
      repeat (n) @(posedge dsp_clk);
   endtask

   task automatic compare(input string name, input logic [31:0] expected,
                          input logic [31:0] actual);
      if (actual !== expected) begin
         $display("CHECK FAILED %s: expected %h, actual %h", name, expected, actual);
         errors++;
      end
   endtask

   // Expected value is the core reset trace, bit 0 = first cycle after the strobe
   task automatic settings_write(input set_addr_t addr, input set_data_t data,
                                 input string name, input logic [31:0] expected);
      logic [3:0] trace;
      @(posedge dsp_clk);
      set_bus <= '{stb: 1'b1, addr: addr, data: data};
      @(posedge dsp_clk);
      set_bus.stb <= 1'b0;
      for (int i = 0; i < 4; i++) begin
         @(negedge dsp_clk);
         trace[i] = core_rst;
      end
      compare(name, expected, 32'(trace));
   endtask

   task automatic rb_read(input rb_index_t index, input string name,
                          input logic [31:0] expected);
      @(posedge dsp_clk);
      rb_index <= index;
      @(posedge dsp_clk);   // Readback word registered here
      @(negedge dsp_clk);
      compare(name, expected, rb_data);
   endtask

   // Pin bits: 0 run_rx, 1 run_tx, 2 clk_status, 3 serdes_link_up, 4 button
   task automatic pins_set(input logic [4:0] pins, input wb_addr_t adr);
      @(posedge dsp_clk);
      run_rx         <= pins[0];
      run_tx         <= pins[1];
      clk_status     <= pins[2];
      serdes_link_up <= pins[3];
      button         <= pins[4];
      cpu_adr        <= adr;
      @(posedge dsp_clk);   // LED register takes the new hardware bits
   endtask

   task automatic output_check(input logic [31:0] sel, input string name,
                               input logic [31:0] expected);
      @(negedge dsp_clk);
      if (sel == 0) begin
         compare(name, expected, 32'(board_ctrl));
      end else if (sel == 1) begin
         compare(name, expected, 32'(phy_resetn));
      end else if (sel == 2) begin
         compare(name, expected, 32'(leds));
      end else if (sel == 3) begin
         compare(name, expected, 32'(mem_adr));
      end else if (sel == 4) begin
         compare(name, expected, 32'(core_rst));
      end else begin
         $display("Unknown output selector %0d in %s", sel, name);
         errors++;
      end
   endtask

   task automatic pps_pulse(input string name, input logic [31:0] expected);
      int cycles;
      int pulses;
      cycles = 0;
      pulses = 0;
      @(posedge dsp_clk);
      pps <= 1'b1;
      do begin
         @(negedge dsp_clk);
         cycles++;
      end while (pps_int !== 1'b1 && cycles < PPS_TIMEOUT);
      if (pps_int !== 1'b1) begin
         $display("Timeout in %s: pps_int_o did not rise within %0d cycles", name, cycles);
         errors++;
      end else begin
         pulses = 1;
         repeat (PPS_WINDOW) begin
            @(negedge dsp_clk);
            if (pps_int === 1'b1) begin
               pulses++;
            end
         end
         compare(name, expected, 32'(pulses));
      end
      @(posedge dsp_clk);
      pps <= 1'b0;
   endtask

   ////////////////////////////////////////
   // Pattern player
   ////////////////////////////////////////
   initial begin
      int          fd;
      int          code;
      int          errors_before;
      string       op;
      string       name;
      string       rest;
      logic [31:0] f_addr;
      logic [31:0] f_data;
      logic [31:0] f_exp;

      por_rst        = 1'b1;
      set_bus        = '0;
      pps            = 1'b0;
      cpu_adr        = '0;
      run_rx         = 1'b0;
      run_tx         = 1'b0;
      clk_status     = 1'b0;
      serdes_link_up = 1'b0;
      button         = 1'b0;
      rb_index       = '0;
      lfsr           = 32'h796b;
      errors         = 0;
      tests          = 0;
      failed         = 0;

      repeat (8) @(posedge dsp_clk);
      por_rst <= 1'b0;

      fd = $fopen("tb/u2_patterns.txt", "r");
      if (fd == 0) begin
         $display("Cannot open the pattern file tb/u2_patterns.txt");
         errors++;
      end else begin
         while (!$feof(fd)) begin
            code = $fscanf(fd, "%s", op);
            if (code != 1) begin
               break;
            end
            if (op.substr(0, 0) == "#") begin
               code = $fgets(rest, fd);   // Column description
            end else begin
               code = $fscanf(fd, "%h %h %h %s", f_addr, f_data, f_exp, name);
               if (code != 4) begin
                  $display("Malformed pattern line after operation %s", op);
                  errors++;
                  break;
               end
               errors_before = errors;
               idle_gap();
               if (op == "write") begin
                  settings_write(set_addr_t'(f_addr), f_data, name, f_exp);
               end else if (op == "read") begin
                  rb_read(rb_index_t'(f_addr), name, f_exp);
               end else if (op == "pins") begin
                  pins_set(f_addr[4:0], wb_addr_t'(f_data));
               end else if (op == "pps") begin
                  pps_pulse(name, f_exp);
               end else if (op == "wait") begin
                  repeat (f_addr) @(posedge dsp_clk);
               end else if (op == "check") begin
                  output_check(f_addr, name, f_exp);
               end else begin
                  $display("Unknown operation %s in the pattern file", op);
                  errors++;
               end
               tests++;
               if (errors != errors_before) begin
                  failed++;
                  $display("fail  %s", name);
               end else begin
                  $display("ok    %s", name);
               end
            end
         end
         $fclose(fd);
      end

      $display("Summary: %0d tests, %0d failed, %0d errors", tests, failed, errors);
      if (errors == 0) begin
         $display("*** TEST PASSED ***");
      end else begin
         $display("*** TEST FAILED ***");
      end
      $finish;
   end

endmodule

// File: tb/u2_patterns.txt
# op addr data expect name, numbers in hex; write expects the core reset trace
# check selects 0 board_ctrl 1 phy_resetn 2 leds 3 mem_adr 4 core_rst; pins takes pin bits and cpu_adr
pins   05  0100  0        pins_rx_clk
check  0   0     0        rst_board_ctrl
check  1   0     1        rst_phy_resetn
read   c   0     00080002 rst_compat
check  2   0     0c       rst_leds_hw
write  0   15    0        wr_clk_ctrl
write  1   9     0        wr_ser_ctrl
write  2   6     0        wr_adc_ctrl
check  0   0     1596     board_ctrl_mapped
write  4   1     0        wr_phy_reset
check  1   0     0        phy_resetn_low
write  3   a5    0        wr_led_sw
write  6   0f    0        wr_led_src
check  2   0     ac       leds_mux
check  3   0     c100     boot_addr_swap
write  5   1     2        boot_release_pulse
check  0   0     0        boot_board_ctrl_dflt
check  1   0     1        boot_phy_resetn_dflt
check  2   0     0c       boot_leds_dflt
check  3   0     0100     boot_addr_direct
write  a   5     0        wr_time_secs
write  b   632e9fd 0      wr_time_ticks
wait   c   0     0        wait_rollover
read   a   0     6        time_rollover_secs
write  a   9     0        wr_pps_secs
write  b   0     0        wr_pps_ticks
pps    0   0     1        pps_one_pulse
read   e   0     9        pps_capture_secs
pins   1c  0100  0        pins_flags
read   d   0     2c00     flags_all
pins   10  0100  0        pins_button
read   d   0     2000     flags_button

// File: sources.f
+incdir+common
common/ctrl_pkg.sv
common/time_pkg.sv
src/boot_reset_seq.sv
vita/vita_time_counter.sv
src/misc_setting_bank.sv
src/status_readback.sv
src/u2_ctrl_core.sv
tb/u2_ctrl_core_props.sv
tb/tb_u2_ctrl_core.sv

// File: Makefile
VERILATOR ?= verilator
TOP       := tb_u2_ctrl_core
FILELIST  := sources.f
FLAGS     := --sv --timing --assert
OBJ_DIR   := obj_dir
PASS_MSG  := *** TEST PASSED ***

.PHONY: lint build sim clean

lint:
	$(VERILATOR) --lint-only $(FLAGS) --top-module $(TOP) -f $(FILELIST)

build:
	$(VERILATOR) --binary -j 0 $(FLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(OBJ_DIR)

# Status comes from the search for the pass line
sim: build
	@out="$$(./$(OBJ_DIR)/V$(TOP))"; \
	echo "$$out"; \
	echo "$$out" | grep -qF '$(PASS_MSG)'

clean:
	rm -rf $(OBJ_DIR)
